//--- rtl/fetch_pkg.sv
// bus types, widths and sizing for the instruction memory bus; imported by every block on it
package fetch_pkg;

	// byte address and word widths of the instruction memory bus
	localparam int addr_w = 16;
	localparam int data_w = 32;

	// memory depth in words and the word index width that goes with it
	localparam int mem_words = 4096;
	localparam int mem_aw = $clog2(mem_words);

	// the frontend starts fetching here after reset
	localparam logic [addr_w-1:0] reset_vector = '0;

	// prefetch queue depth, any power of two of at least 2 works
	localparam int queue_depth = 4;

	// one memory request, req is the only qualifier for the other fields
	typedef struct packed {
		logic              req;
		logic              we;
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] wdata;
	} mem_req_t;

	// one read response, rdata is only meaningful while rvalid is high
	typedef struct packed {
		logic              rvalid;
		logic [data_w-1:0] rdata;
	} mem_rsp_t;

	// tag kept by the arbiter for the read that is on its way back
	typedef enum logic {
		owner_host,
		owner_fetch
	} owner_e;

endpackage

//--- rtl/isa_pkg.sv
// RV32IC opcode encodings and the rs1/rs2 predecode rule, imported by the fetch frontend
package isa_pkg;

	// the two low bits of an instruction pick a compressed quadrant or a 32-bit instruction
	typedef enum logic [1:0] {
		q0     = 2'b00,
		q1     = 2'b01,
		q2     = 2'b10,
		q_full = 2'b11
	} quadrant_e;

	// compressed opcodes that predecode treats specially
	// each value is the quadrant followed by funct3, because funct3 alone repeats between quadrants
	typedef enum logic [4:0] {
		c_addi4spn = 5'b00_000,
		c_addi     = 5'b01_000,
		c_addi16sp = 5'b01_011,
		c_lwsp     = 5'b10_010,
		c_swsp     = 5'b10_110
	} c_funct3_e;

	// register numbers that go to the register file read ports
	typedef struct packed {
		logic [4:0] rs1;
		logic [4:0] rs2;
	} regs_t;

	// cheap guess of rs1/rs2, exact for the formats that read registers
	function automatic regs_t predecode_regs(input logic [31:0] instr);
		regs_t     regs;
		quadrant_e quad;
		c_funct3_e op;
		quad = quadrant_e'(instr[1:0]);
		op = c_funct3_e'({instr[1:0], instr[15:13]});
		if (quad == q_full) begin
			regs.rs1 = instr[19:15];
			regs.rs2 = instr[24:20];
		end else begin
			// quadrant 2 has full rs2 fields, the others use the popular x8..x15 subset
			regs.rs2 = (quad == q2) ? instr[6:2] : {2'b01, instr[4:2]};
			case (op)
				// stack pointer relative forms read sp
				c_addi4spn, c_addi16sp, c_lwsp, c_swsp: regs.rs1 = 5'd2;
				c_addi: regs.rs1 = instr[11:7];
				default: regs.rs1 = (quad == q2) ? instr[11:7] : {2'b01, instr[9:7]};
			endcase
		end
		return regs;
	endfunction

endpackage

//--- rtl/fetch_queue.sv
// prefetch queue for fetched words; the head always sits in entry zero so it can be muxed with bus data
module fetch_queue #(
	parameter int depth = 4
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           flush,
	input  logic                           push,
	input  logic [fetch_pkg::data_w-1:0]   wdata,
	input  logic                           pop,
	output logic [fetch_pkg::data_w-1:0]   rdata,
	output logic                           empty,
	output logic                           full,
	output logic [$clog2(depth+1)-1:0]     level
);
	import fetch_pkg::*;

	logic [data_w-1:0] mem_q [depth];
	logic [data_w-1:0] above [depth];
	logic [depth-1:0]  valid_q;
	logic [depth:0]    valid_ext;

	// an extra invalid entry on top keeps the shift loop free of edge cases
	assign valid_ext = {1'b0, valid_q};

	// the word each entry takes on a shift, the top entry refills from the write port
	always_comb begin
		for (int i = 0; i < depth - 1; i++) begin
			above[i] = mem_q[i + 1];
		end
		above[depth - 1] = wdata;
	end

	// --------------------------------------------------
	// storage

	// on a pop every entry moves down, and the first free slot takes the pushed word
	always_ff @(posedge clk) begin
		for (int i = 0; i < depth; i++) begin
			if (pop || (push && !valid_q[i])) begin
				mem_q[i] <= valid_ext[i + 1] ? above[i] : wdata;
			end
		end
	end

	// valid bits stay packed against entry zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (flush) begin
			valid_q <= '0;
		end else begin
			case ({push, pop})
				2'b10: valid_q <= {valid_q[depth-2:0], 1'b1};
				2'b01: valid_q <= valid_ext[depth:1];
				default: valid_q <= valid_q;
			endcase
		end
	end

	// --------------------------------------------------
	// status

	always_comb begin
		level = '0;
		for (int i = 0; i < depth; i++) begin
			if (valid_q[i]) begin
				level = level + 1'b1;
			end
		end
	end

	assign rdata = mem_q[0];
	assign empty = !valid_q[0];
	assign full = valid_q[depth - 1];

	// the frontend reserves an entry for every word in flight, so a returning word finds room
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);

endmodule

//--- rtl/fetch_frontend.sv
// fetch frontend; requests words, buffers them, assembles cir and predecodes the next registers
module fetch_frontend (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          jump_strobe,
	input  logic [fetch_pkg::addr_w-1:0]  jump_target,
	output fetch_pkg::mem_req_t           fetch_req,
	input  logic                          fetch_gnt,
	input  fetch_pkg::mem_rsp_t           fetch_rsp,
	output logic [31:0]                   cir,
	output logic [1:0]                    cir_vld,
	input  logic [1:0]                    cir_use,
	input  logic                          cir_lock,
	output logic [4:0]                    next_rs1,
	output logic [4:0]                    next_rs2
);
	import fetch_pkg::*;
	import isa_pkg::*;

	logic                              req_q;
	logic [addr_w-1:0]                 fetch_addr_q;
	logic [1:0]                        inflight_q;
	logic [1:0]                        inflight_nxt;
	logic [1:0]                        flush_q;
	logic                              xfer;
	logic                              data_live;
	logic                              can_issue;
	logic                              q_push;
	logic                              q_pop;
	logic                              q_empty;
	logic                              q_full;
	logic [data_w-1:0]                 q_rdata;
	logic [$clog2(queue_depth+1)-1:0]  q_level;
	logic [47:0]                       yard_q;
	logic [47:0]                       yard_sh;
	logic [47:0]                       yard_nxt;
	logic [1:0]                        lvl_q;
	logic [1:0]                        lvl_rem;
	logic [1:0]                        lvl_nxt;
	logic                              mis_q;
	logic [31:0]                       fetch_data;
	logic                              fetch_vld;
	logic                              take;
	regs_t                             next_regs;

	fetch_queue #(
		.depth(queue_depth)
	) u_queue (
		.clk(clk),
		.rst_n(rst_n),
		.flush(jump_strobe),
		.push(q_push),
		.wdata(fetch_rsp.rdata),
		.pop(q_pop),
		.rdata(q_rdata),
		.empty(q_empty),
		.full(q_full),
		.level(q_level)
	);

	// --------------------------------------------------
	// fetch requests

	assign fetch_req = '{req: req_q, we: 1'b0, addr: fetch_addr_q, wdata: '0};
	assign xfer = fetch_req.req && fetch_gnt;
	assign inflight_nxt = inflight_q + {1'b0, xfer} - {1'b0, fetch_rsp.rvalid};

	// words still owed to a flushed stream are dropped, as is anything landing on a jump
	assign data_live = fetch_rsp.rvalid && (flush_q == 2'd0) && !jump_strobe;

	// every word in flight keeps a queue entry reserved, pops this cycle are ignored
	assign can_issue = !q_full && (inflight_nxt < 2'd2)
		&& (int'(q_level) + int'(inflight_q) + int'(xfer) < queue_depth);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_q <= 1'b0;
			fetch_addr_q <= reset_vector;
			inflight_q <= 2'd0;
			flush_q <= 2'd0;
		end else begin
			inflight_q <= inflight_nxt;
			if (jump_strobe) begin
				// an ungranted request leaves no state in the arbiter, so it is simply retargeted
				fetch_addr_q <= {jump_target[addr_w-1:2], 2'b00};
				req_q <= inflight_nxt < 2'd2;
				flush_q <= inflight_nxt;
			end else begin
				if (xfer) begin
					fetch_addr_q <= fetch_addr_q + addr_w'(4);
				end
				// a denied request holds its address until granted
				if (!req_q || fetch_gnt) begin
					req_q <= can_issue;
				end
				if ((flush_q != 2'd0) && fetch_rsp.rvalid) begin
					flush_q <= flush_q - 2'd1;
				end
			end
		end
	end

	// --------------------------------------------------
	// instruction assembly yard

	// yard_q holds {spare halfword, cir} and lvl_q counts its valid halfwords
	assign fetch_data = q_empty ? fetch_rsp.rdata : q_rdata;
	assign fetch_vld = !q_empty || data_live;
	assign lvl_rem = lvl_q - cir_use;

	// refill whenever less than a full cir would remain
	assign take = !cir_lock && !jump_strobe && !lvl_rem[1] && fetch_vld;
	assign q_pop = take && !q_empty;

	// bus data that goes straight into the yard is not queued as well
	assign q_push = data_live && !(take && q_empty);

	always_comb begin
		// shift out what decode consumed, the unused upper slots are don't care
		case (cir_use)
			2'd1: yard_sh = {yard_q[47:32], yard_q[47:16]};
			2'd2: yard_sh = {yard_q[47:32], yard_q[47:32], yard_q[47:32]};
			default: yard_sh = yard_q;
		endcase
		yard_nxt = yard_sh;
		lvl_nxt = lvl_rem;
		if (cir_lock) begin
			yard_nxt = yard_q;
			lvl_nxt = lvl_q;
		end else if (take) begin
			if (mis_q) begin
				// first word after a misaligned jump, only its upper halfword belongs to the stream
				yard_nxt = {yard_sh[47:16], fetch_data[31:16]};
				lvl_nxt = lvl_rem + 2'd1;
			end else if (lvl_rem[0]) begin
				yard_nxt = {fetch_data, yard_sh[15:0]};
				lvl_nxt = 2'd3;
			end else begin
				yard_nxt = {yard_sh[47:32], fetch_data};
				lvl_nxt = 2'd2;
			end
		end
		if (jump_strobe) begin
			lvl_nxt = 2'd0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lvl_q <= 2'd0;
			mis_q <= 1'b0;
		end else begin
			lvl_q <= lvl_nxt;
			if (jump_strobe) begin
				mis_q <= jump_target[1];
			end else if (take) begin
				mis_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		yard_q <= yard_nxt;
	end

	assign cir = yard_q[31:0];
	assign cir_vld = lvl_q[1] ? 2'd2 : lvl_q;

	// --------------------------------------------------
	// register predecode of the value cir takes next

	assign next_regs = predecode_regs(yard_nxt[31:0]);
	assign next_rs1 = next_regs.rs1;
	assign next_rs2 = next_regs.rs2;

	// at most two words may be outstanding on the fetch bus
	a_inflight: assert property (@(posedge clk) disable iff (!rst_n) inflight_q <= 2'd2);

	// decode only consumes halfwords that cir already holds
	a_cir_use: assert property (@(posedge clk) disable iff (!rst_n) cir_use <= cir_vld);

endmodule

//--- rtl/mem_arbiter.sv
// fixed-priority arbiter between the host port and instruction fetch on the single memory port
module mem_arbiter (
	input  logic                 clk,
	input  logic                 rst_n,
	input  fetch_pkg::mem_req_t  host_req,
	output fetch_pkg::mem_rsp_t  host_rsp,
	input  fetch_pkg::mem_req_t  fetch_req,
	output logic                 fetch_gnt,
	output fetch_pkg::mem_rsp_t  fetch_rsp,
	output fetch_pkg::mem_req_t  mem_req,
	input  fetch_pkg::mem_rsp_t  mem_rsp
);
	import fetch_pkg::*;

	owner_e owner_q;

	// the host always wins, fetch only gets idle cycles
	assign fetch_gnt = fetch_req.req && !host_req.req;

	// fetch_req passes through with req low when nobody asks
	assign mem_req = host_req.req ? host_req : fetch_req;

	// remember who issued the read so the data returns to the right port
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			owner_q <= owner_host;
		end else if (mem_req.req && !mem_req.we) begin
			owner_q <= host_req.req ? owner_host : owner_fetch;
		end
	end

	// --------------------------------------------------
	// response steering

	always_comb begin
		host_rsp.rdata = mem_rsp.rdata;
		fetch_rsp.rdata = mem_rsp.rdata;
		host_rsp.rvalid = mem_rsp.rvalid && (owner_q == owner_host);
		fetch_rsp.rvalid = mem_rsp.rvalid && (owner_q == owner_fetch);
	end

	// each memory slot belongs to exactly one requester, a response follows its own grant
	a_fetch_owner: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_rsp.rvalid |-> $past(fetch_gnt));
	a_host_owner: assert property (@(posedge clk) disable iff (!rst_n)
		host_rsp.rvalid |-> $past(host_req.req && !host_req.we));

endmodule

//--- rtl/inst_mem.sv
// single-port instruction memory; writes land in the request cycle, reads return a cycle later
module inst_mem (
	input  logic                 clk,
	input  logic                 rst_n,
	input  fetch_pkg::mem_req_t  req,
	output fetch_pkg::mem_rsp_t  rsp
);
	import fetch_pkg::*;

	logic [data_w-1:0] mem_q [mem_words];
	logic [mem_aw-1:0] idx;
	logic [data_w-1:0] rdata_q;
	logic              rvalid_q;

	// word index, the byte offset bits are ignored
	assign idx = req.addr[mem_aw+1:2];

	always_ff @(posedge clk) begin
		if (req.req && req.we) begin
			mem_q[idx] <= req.wdata;
		end
		if (req.req && !req.we) begin
			rdata_q <= mem_q[idx];
		end
	end

	// rvalid marks the cycle after each read request
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rvalid_q <= 1'b0;
		end else begin
			rvalid_q <= req.req && !req.we;
		end
	end

	assign rsp = '{rvalid: rvalid_q, rdata: rdata_q};

endmodule

//--- rtl/fetch_subsystem.sv
// top level of the fetch subsystem, joining frontend, arbiter and memory behind host and decode ports
module fetch_subsystem (
	input  logic                          clk,
	input  logic                          rst_n,
	input  fetch_pkg::mem_req_t           host_req,
	output fetch_pkg::mem_rsp_t           host_rsp,
	input  logic                          jump_strobe,
	input  logic [fetch_pkg::addr_w-1:0]  jump_target,
	output logic [31:0]                   cir,
	output logic [1:0]                    cir_vld,
	input  logic [1:0]                    cir_use,
	input  logic                          cir_lock,
	output logic [4:0]                    next_rs1,
	output logic [4:0]                    next_rs2
);
	import fetch_pkg::*;

	// fetch side of the arbiter
	mem_req_t fetch_req;
	logic     fetch_gnt;
	mem_rsp_t fetch_rsp;

	// memory side of the arbiter
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;

	fetch_frontend u_frontend (
		.clk(clk),
		.rst_n(rst_n),
		.jump_strobe(jump_strobe),
		.jump_target(jump_target),
		.fetch_req(fetch_req),
		.fetch_gnt(fetch_gnt),
		.fetch_rsp(fetch_rsp),
		.cir(cir),
		.cir_vld(cir_vld),
		.cir_use(cir_use),
		.cir_lock(cir_lock),
		.next_rs1(next_rs1),
		.next_rs2(next_rs2)
	);

	mem_arbiter u_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.host_req(host_req),
		.host_rsp(host_rsp),
		.fetch_req(fetch_req),
		.fetch_gnt(fetch_gnt),
		.fetch_rsp(fetch_rsp),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	inst_mem u_mem (
		.clk(clk),
		.rst_n(rst_n),
		.req(mem_req),
		.rsp(mem_rsp)
	);

endmodule

//--- dv/tb_clkgen.sv
// clock and reset source for the fetch testbench, a 10 unit clock and an 8 cycle active-low reset
module tb_clkgen (
	output logic clk,
	output logic rst_n
);

	localparam int half_period = 5;
	localparam int reset_cycles = 8;

	initial begin
		clk = 1'b0;
		forever begin
			#half_period clk = ~clk;
		end
	end

	// reset lets go just after a rising edge, the same way every other input is driven
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

//--- dv/fetch_tb.sv
// testbench for the fetch subsystem; loads a random RV32IC program over the host port, checks cir
module fetch_tb;
	import fetch_pkg::*;

	// --------------------------------------------------
	// program size and run length

	localparam int n_words = 128;
	localparam int n_hw = 2 * n_words;
	localparam int word_aw = $clog2(n_words);
	localparam int hw_aw = $clog2(n_hw);
	localparam int n_mixed = 600;
	localparam int n_readback = 16;
	localparam int clk_period = 10;
	localparam int load_cycles = n_words + n_readback + 32;
	// every decoded instruction gets 40 cycles, the sequential pass decodes at most n_hw of them
	localparam int wd_cycles = (n_hw + n_mixed) * 40 + load_cycles;

	logic              clk;
	logic              rst_n;
	mem_req_t          host_req;
	mem_rsp_t          host_rsp;
	logic              jump_strobe;
	logic [addr_w-1:0] jump_target;
	logic [31:0]       cir;
	logic [1:0]        cir_vld;
	logic [1:0]        cir_use;
	logic              cir_lock;
	logic [4:0]        next_rs1;
	logic [4:0]        next_rs2;

	// program halfwords as generated, and the memory contents as written by the host
	logic [15:0] halves [n_hw];
	logic [31:0] shadow [n_words];

	int    n_errors;
	int    n_checks;
	int    n_instr;
	int    n_seq;
	int    exp_pc;
	string test_name;

	// a host read issued in the previous cycle and the word it must return
	logic        rd_pending;
	logic [31:0] rd_expect;

	// next_rs1/next_rs2 as seen in the middle of the previous cycle
	logic [9:0]  regs_prev;

	// cir and cir_vld captured in a locked cycle
	logic        lock_prev;
	logic [31:0] cir_hold;
	logic [1:0]  vld_hold;

	tb_clkgen u_clkgen (
		.clk(clk),
		.rst_n(rst_n)
	);

	fetch_subsystem dut (
		.clk(clk),
		.rst_n(rst_n),
		.host_req(host_req),
		.host_rsp(host_rsp),
		.jump_strobe(jump_strobe),
		.jump_target(jump_target),
		.cir(cir),
		.cir_vld(cir_vld),
		.cir_use(cir_use),
		.cir_lock(cir_lock),
		.next_rs1(next_rs1),
		.next_rs2(next_rs2)
	);

	// --------------------------------------------------
	// reference model

	function automatic logic [15:0] half_at(input int hw);
		logic [31:0] word;
		if (hw >= n_hw) begin
			return 16'h0000;
		end
		word = shadow[word_aw'(hw / 2)];
		return (hw % 2 == 1) ? word[31:16] : word[15:0];
	endfunction

	// instruction starting at a halfword address, low bits 11 mean a 32-bit instruction
	function automatic logic [31:0] expected_instr(input int hw, output int len);
		logic [15:0] lo;
		lo = half_at(hw);
		if (lo[1:0] == 2'b11) begin
			len = 2;
			return {half_at(hw + 1), lo};
		end
		len = 1;
		return {16'h0000, lo};
	endfunction

	// rs1/rs2 guess, returned as {rs1, rs2}
	function automatic logic [9:0] predecode_rule(input logic [31:0] instr);
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] key;
		// quadrant and funct3 together name a compressed opcode
		key = {instr[1:0], instr[15:13]};
		if (instr[1:0] == 2'b11) begin
			rs1 = instr[19:15];
			rs2 = instr[24:20];
		end else begin
			rs2 = (instr[1:0] == 2'b10) ? instr[6:2] : {2'b01, instr[4:2]};
			// addi4spn, addi16sp, lwsp and swsp all read the stack pointer
			if (key == 5'b00000 || key == 5'b01011 || key == 5'b10010 || key == 5'b10110) begin
				rs1 = 5'd2;
			end else if (key == 5'b01000 || instr[1:0] == 2'b10) begin
				rs1 = instr[11:7];
			end else begin
				rs1 = {2'b01, instr[9:7]};
			end
		end
		return {rs1, rs2};
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	// --------------------------------------------------
	// stimulus helpers

	task automatic drive_idle();
		host_req = '0;
		jump_strobe = 1'b0;
		cir_use = 2'd0;
		cir_lock = 1'b0;
	endtask

	task automatic host_write(input int word, input logic [31:0] data);
		host_req = '{req: 1'b1, we: 1'b1, addr: addr_w'(word * 4), wdata: data};
		shadow[word_aw'(word)] = data;
	endtask

	task automatic host_read(input int word);
		host_req = '{req: 1'b1, we: 1'b0, addr: addr_w'(word * 4), wdata: '0};
	endtask

	// random mix of 16 and 32-bit instructions, the last halfword is never a 32-bit start
	task automatic build_program();
		int          hw;
		logic [31:0] r;
		hw = 0;
		while (hw < n_hw) begin
			r = $urandom;
			// lean toward 32-bit instructions so misaligned ones show up often
			r[1:0] = r[2] ? 2'b11 : r[1:0];
			if (r[1:0] == 2'b11 && hw == n_hw - 1) begin
				r[1:0] = 2'b01;
			end
			halves[hw_aw'(hw)] = r[15:0];
			if (r[1:0] == 2'b11) begin
				halves[hw_aw'(hw + 1)] = r[31:16];
				hw = hw + 2;
			end else begin
				hw = hw + 1;
			end
		end
		// a jump may land on the final halfword even when it is the upper half of a 32-bit one
		if (halves[hw_aw'(n_hw - 1)][1:0] == 2'b11) begin
			halves[hw_aw'(n_hw - 1)][1:0] = 2'b01;
		end
	endtask

	// one decode cycle; mixed adds jumps, locks, stalls and host reads
	task automatic run_cycle(input bit mixed);
		int          r;
		int          len;
		bit          jump;
		logic [31:0] want;
		logic [31:0] got;
		@(posedge clk);
		#1;
		drive_idle();
		// a locked cycle leaves cir and cir_vld exactly as they were
		if (lock_prev) begin
			check_value("lock_cir", cir_hold, cir);
			check_value("lock_vld", 32'(vld_hold), 32'(cir_vld));
		end
		lock_prev = 1'b0;
		r = $urandom % 32;
		// running off the end of the program forces a jump back into it
		jump = (exp_pc >= n_hw) || (mixed && r == 0);
		if (jump) begin
			exp_pc = $urandom % n_hw;
			jump_strobe = 1'b1;
			jump_target = addr_w'(exp_pc * 2);
		end else if (mixed && (r == 1 || r == 2)) begin
			cir_lock = 1'b1;
			lock_prev = 1'b1;
			cir_hold = cir;
			vld_hold = cir_vld;
		end else if (!(mixed && (r == 3 || r == 4)) && cir_vld != 2'd0) begin
			want = expected_instr(exp_pc, len);
			if (int'(cir_vld) >= len) begin
				got = (len == 2) ? cir : {16'h0000, cir[15:0]};
				check_value("cir", want, got);
				check_value("next_regs", 32'(predecode_rule(want)), 32'(regs_prev));
				cir_use = 2'(len);
				exp_pc = exp_pc + len;
				n_instr++;
			end
		end
		if (mixed && ($urandom % 6 == 0)) begin
			host_read($urandom % n_words);
		end
	endtask

	// --------------------------------------------------
	// host response monitor

	// every read strobe is answered in the next cycle and at no other time
	always @(negedge clk) begin
		if (rst_n) begin
			check_value("host_rvalid", 32'(rd_pending), 32'(host_rsp.rvalid));
			if (rd_pending) begin
				check_value("host_rdata", rd_expect, host_rsp.rdata);
			end
			regs_prev = {next_rs1, next_rs2};
			rd_pending = host_req.req && !host_req.we;
			rd_expect = shadow[host_req.addr[word_aw+1:2]];
		end
	end

	// --------------------------------------------------
	// main sequence

	initial begin
		void'($urandom(32'h2437));
		drive_idle();
		// cir stays empty while the program is loaded, whatever fetch picks up meanwhile
		cir_lock = 1'b1;
		jump_target = '0;
		n_errors = 0;
		n_checks = 0;
		n_instr = 0;
		exp_pc = 0;
		rd_pending = 1'b0;
		rd_expect = '0;
		regs_prev = '0;
		lock_prev = 1'b0;
		test_name = "reset";
		build_program();

		@(posedge rst_n);
		@(posedge clk);
		#1;
		check_value("cir_vld", 32'd0, 32'(cir_vld));
		check_value("host_rvalid", 32'd0, 32'(host_rsp.rvalid));

		test_name = "load";
		for (int i = 0; i < n_words; i++) begin
			@(posedge clk);
			#1;
			host_write(i, {halves[hw_aw'(2 * i + 1)], halves[hw_aw'(2 * i)]});
		end
		test_name = "readback";
		for (int i = 0; i < n_readback; i++) begin
			@(posedge clk);
			#1;
			host_read($urandom % n_words);
		end

		// the jump throws away everything fetched while memory was still being written
		test_name = "sequential";
		@(posedge clk);
		#1;
		drive_idle();
		jump_strobe = 1'b1;
		jump_target = reset_vector;
		exp_pc = int'(reset_vector) / 2;
		while (exp_pc < n_hw) begin
			run_cycle(1'b0);
		end

		test_name = "mixed";
		n_seq = n_instr;
		while (n_instr < n_seq + n_mixed) begin
			run_cycle(1'b1);
		end
		@(posedge clk);
		#1;
		drive_idle();
		// give the last host read time to come back
		repeat (2) @(posedge clk);
		#1;

		$display("instructions %0d, checks %0d, errors %0d", n_instr, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// watchdog for a stream that stops delivering instructions
	initial begin
		#(wd_cycles * clk_period);
		$display("timeout after %0d cycles with %0d instructions decoded", wd_cycles, n_instr);
		$display("sim failed");
		$finish;
	end

endmodule

//--- list.f
rtl/fetch_pkg.sv
rtl/isa_pkg.sv
rtl/fetch_queue.sv
rtl/fetch_frontend.sv
rtl/mem_arbiter.sv
rtl/inst_mem.sv
rtl/fetch_subsystem.sv
dv/tb_clkgen.sv
dv/fetch_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -f list.f --top-module fetch_tb -o fetch_sim \
	&& ./obj_dir/fetch_sim | tee /dev/stderr | grep -x "sim passed" > /dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
